/* common/egr_consts.svh */
//==========================================================================
// Egress port controller constants
// Port and traffic class counts, FIFO depth, link credits and the
// widths of the segment fields and the SECDED check code
//==========================================================================

`ifndef EGR_CONSTS_SVH
`define EGR_CONSTS_SVH

// Egress ports and traffic classes
`define EGR_NUM_PORTS    4
`define EGR_NUM_TC       8

// Segment FIFO entries
`define EGR_FIFO_DEPTH   4

// Link credits per port after reset, counter saturates at 15
`define EGR_INIT_CREDITS 3
`define EGR_CREDIT_W     4

// Segment payload and check code
`define EGR_DATA_W       64
`define EGR_META_W       16
`define EGR_ECC_W        8

`endif

/* common/egr_pkg.sv */
//==========================================================================
// Egress port controller types
// Port, traffic class and credit types and the packed segment that
// travels from the input FIFO through credit control to the ECC stage
//==========================================================================

`include "egr_consts.svh"

package egr_pkg;

  //========================================================================
  // Index and counter types
  //========================================================================

  // Destination port number
  typedef logic [$clog2(`EGR_NUM_PORTS)-1:0] port_idx_t;

  // Traffic class, also the PFC pause bit index
  typedef logic [$clog2(`EGR_NUM_TC)-1:0] tc_idx_t;

  // Per-port link credit count
  typedef logic [`EGR_CREDIT_W-1:0] credit_t;

  //========================================================================
  // Segment
  //========================================================================

  // 85 bits, port in the top bits and data in the bottom bits
  typedef struct packed {
    port_idx_t               port;
    tc_idx_t                 tc;
    logic [`EGR_META_W-1:0]  meta;
    logic [`EGR_DATA_W-1:0]  data;
  } egr_seg_t;

endpackage

/* common/egr_seg_if.sv */
//==========================================================================
// Segment handshake interface
// Valid/ready link carrying one egr_seg_t, transfer on a rising edge
// with valid and ready both high, source holds its values until then
//==========================================================================

`timescale 1ns/1ns

interface egr_seg_if;
  import egr_pkg::*;

  // Handshake
  logic     valid;
  logic     ready;

  // Payload, stable while valid waits for ready
  egr_seg_t seg;

  // Segment producer
  modport src (
    output valid,
    output seg,
    input  ready
  );

  // Segment consumer
  modport dst (
    input  valid,
    input  seg,
    output ready
  );

endinterface

/* hw/egr_credit_ctl.sv */
//==========================================================================
// Egress credit control
// One link credit counter per port plus PFC pause gating, lets the FIFO
// head through only when its port has credit and its TC is not paused
//==========================================================================

`timescale 1ns/1ns

`include "egr_consts.svh"

module egr_credit_ctl (
  input  logic                   primary_clock,
  input  logic                   rst_n,
  egr_seg_if.dst                 head,
  egr_seg_if.src                 sched,
  input  logic                   credit_valid,
  input  egr_pkg::port_idx_t     credit_port,
  input  egr_pkg::credit_t       credit_count,
  input  logic [`EGR_NUM_TC-1:0] pfc_xoff
);
  import egr_pkg::*;

  localparam int NPORT = `EGR_NUM_PORTS;
  localparam int CW    = `EGR_CREDIT_W;

  // Credits held per port
  credit_t   credits [NPORT];

  port_idx_t sel_port;
  tc_idx_t   sel_tc;
  credit_t   cur_credit;
  logic      may_send;
  logic      xfer;
  logic      ret_hit;

  // Return plus optional send, saturating at the counter maximum
  function automatic credit_t credit_next(
    input credit_t cur,
    input logic    add_en,
    input credit_t add,
    input logic    take
  );
    logic [CW+1:0] sum;
    sum = {2'b00, cur} + (add_en ? {2'b00, add} : '0) - {{(CW + 1){1'b0}}, take};
    // Sends only happen with credit, so sum never goes negative
    return (sum > {2'b00, {CW{1'b1}}}) ? {CW{1'b1}} : sum[CW-1:0];
  endfunction

  //========================================================================
  // Dequeue decision
  //========================================================================

  assign sel_port    = head.seg.port;
  assign sel_tc      = head.seg.tc;
  assign cur_credit  = credits[sel_port];

  // Needs one credit and an open TC
  assign may_send    = (cur_credit != '0) && !pfc_xoff[sel_tc];

  // Straight pass-through, no register in this path
  assign sched.valid = head.valid && may_send;
  assign sched.seg   = head.seg;
  assign head.ready  = sched.ready && may_send;

  assign xfer        = sched.valid && sched.ready;
  // Return aimed at the port being sent to
  assign ret_hit     = credit_valid && (credit_port == sel_port);

  //========================================================================
  // Credit counters
  //========================================================================

  // Return and send on one port in one cycle net out
  always_ff @(posedge primary_clock) begin
    for (int p = 0; p < NPORT; p++) begin
      if (!rst_n) begin
        credits[p] <= credit_t'(`EGR_INIT_CREDITS);
      end else begin
        credits[p] <= credit_next(credits[p],
                                  credit_valid && (credit_port == port_idx_t'(p)),
                                  credit_count,
                                  xfer && (sel_port == port_idx_t'(p)));
      end
    end
  end

  // A send without a return lowers the count and never wraps it
  a_credit_consumed: assert property (@(posedge primary_clock) disable iff (!rst_n)
    (xfer && !ret_hit) |=> (credits[$past(sel_port)] < $past(cur_credit)));

endmodule

/* hw/egr_ecc_gen.sv */
//==========================================================================
// Egress SECDED encoder and CDI transmit stage
// Extended Hamming (72,64) check code over the segment data, registered
// with the segment onto the transmit signals for one cycle per beat
//==========================================================================

`timescale 1ns/1ns

`include "egr_consts.svh"

module egr_ecc_gen (
  input  logic                   primary_clock,
  input  logic                   rst_n,
  egr_seg_if.dst                 sched,
  output logic                   tx_valid,
  output egr_pkg::port_idx_t     tx_port,
  output egr_pkg::tc_idx_t       tx_tc,
  output logic [`EGR_META_W-1:0] tx_meta,
  output logic [`EGR_DATA_W-1:0] tx_data,
  output logic [`EGR_ECC_W-1:0]  tx_ecc
);

  // Hamming positions 1 to 71 plus the overall parity
  localparam int CODE_N = `EGR_DATA_W + `EGR_ECC_W;

  logic                  xfer;
  logic [`EGR_ECC_W-1:0] code;

  //========================================================================
  // Check code
  //========================================================================

  // Data fills non power of two positions in ascending order
  function automatic logic [`EGR_ECC_W-1:0] secded(input logic [`EGR_DATA_W-1:0] d);
    logic [`EGR_ECC_W-2:0] chk;
    logic [`EGR_ECC_W-2:0] pos;
    int                    di;
    chk = '0;
    di  = 0;
    for (int p = 1; p < CODE_N; p++) begin
      pos = p[`EGR_ECC_W-2:0];
      // Powers of two are check bit slots
      if ((p & (p - 1)) != 0) begin
        for (int k = 0; k < `EGR_ECC_W - 1; k++) begin
          if (pos[k]) begin
            chk[k] = chk[k] ^ d[di];
          end
        end
        di = di + 1;
      end
    end
    // Top bit covers all data and all seven check bits
    return {(^d) ^ (^chk), chk};
  endfunction

  assign code = secded(sched.seg.data);

  //========================================================================
  // Transmit register
  //========================================================================

  // Link has no back-pressure
  assign sched.ready = 1'b1;
  assign xfer        = sched.valid && sched.ready;

  // One beat per transfer
  always_ff @(posedge primary_clock) begin
    if (!rst_n) begin
      tx_valid <= 1'b0;
    end else begin
      tx_valid <= xfer;
    end
  end

  // Payload only loads on a transfer
  always_ff @(posedge primary_clock) begin
    if (xfer) begin
      tx_port <= sched.seg.port;
      tx_tc   <= sched.seg.tc;
      tx_meta <= sched.seg.meta;
      tx_data <= sched.seg.data;
      tx_ecc  <= code;
    end
  end

  // Every transmitted codeword has even overall parity
  a_beat_per_xfer: assert property (@(posedge primary_clock) disable iff (!rst_n)
    tx_valid |-> ((^{tx_data, tx_ecc}) == 1'b0));

endmodule

/* hw/egr_seg_fifo.sv */
//==========================================================================
// Egress segment FIFO
// In-order circular buffer, one write and one read per cycle, oldest
// segment presented at the head the cycle after it is written
//==========================================================================

`timescale 1ns/1ns

`include "egr_consts.svh"

module egr_seg_fifo (
  input  logic             primary_clock,
  input  logic             rst_n,
  input  logic             in_valid,
  output logic             in_ready,
  input  egr_pkg::egr_seg_t in_seg,
  egr_seg_if.src           head
);
  import egr_pkg::*;

  localparam int DEPTH = `EGR_FIFO_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam logic [PTR_W:0] FULL_CNT = (PTR_W + 1)'(DEPTH);
  localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);

  // Segment storage
  egr_seg_t mem [DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  // Occupancy, 0 to DEPTH
  logic [PTR_W:0]   count;
  logic             wr_en;
  logic             rd_en;

  // Back-pressure only when every entry is taken
  assign in_ready   = (count != FULL_CNT);
  assign wr_en      = in_valid && in_ready;
  assign rd_en      = head.valid && head.ready;

  // Head is the oldest entry
  assign head.valid = (count != '0);
  assign head.seg   = mem[rd_ptr];

  // Storage write
  always_ff @(posedge primary_clock) begin
    if (wr_en) begin
      mem[wr_ptr] <= in_seg;
    end
  end

  // Pointers and occupancy
  always_ff @(posedge primary_clock) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
      end
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Occupancy never grows past full
  a_no_overflow: assert property (@(posedge primary_clock) disable iff (!rst_n)
    count <= FULL_CNT);

  // Nothing is read out of an empty buffer
  a_no_underflow: assert property (@(posedge primary_clock) disable iff (!rst_n)
    (count == '0) |=> (rd_ptr == $past(rd_ptr)));

endmodule

/* hw/egr_top.sv */
//==========================================================================
// Egress port controller top level
// Segment FIFO, credit and PFC control and SECDED transmit stage, with
// link-partner credit returns and pause mask as plain inputs
//==========================================================================

`timescale 1ns/1ns

`include "egr_consts.svh"

module egr_top (
  input  logic                   primary_clock,
  input  logic                   rst_n,
  // Segment input
  input  logic                   in_valid,
  output logic                   in_ready,
  input  egr_pkg::port_idx_t     in_port,
  input  egr_pkg::tc_idx_t       in_tc,
  input  logic [`EGR_META_W-1:0] in_meta,
  input  logic [`EGR_DATA_W-1:0] in_data,
  // Link partner credit return and pause
  input  logic                   credit_valid,
  input  egr_pkg::port_idx_t     credit_port,
  input  egr_pkg::credit_t       credit_count,
  input  logic [`EGR_NUM_TC-1:0] pfc_xoff,
  // CDI transmit
  output logic                   tx_valid,
  output egr_pkg::port_idx_t     tx_port,
  output egr_pkg::tc_idx_t       tx_tc,
  output logic [`EGR_META_W-1:0] tx_meta,
  output logic [`EGR_DATA_W-1:0] tx_data,
  output logic [`EGR_ECC_W-1:0]  tx_ecc
);
  import egr_pkg::*;

  // Input fields packed into one segment
  egr_seg_t in_seg;

  assign in_seg = '{port: in_port, tc: in_tc, meta: in_meta, data: in_data};

  // FIFO head to credit control, credit control to ECC stage
  egr_seg_if fifo_q ();
  egr_seg_if sched_q ();

  egr_seg_fifo u_fifo (
    .primary_clock (primary_clock),
    .rst_n         (rst_n),
    .in_valid      (in_valid),
    .in_ready      (in_ready),
    .in_seg        (in_seg),
    .head          (fifo_q)
  );

  egr_credit_ctl u_credit (
    .primary_clock (primary_clock),
    .rst_n         (rst_n),
    .head          (fifo_q),
    .sched         (sched_q),
    .credit_valid  (credit_valid),
    .credit_port   (credit_port),
    .credit_count  (credit_count),
    .pfc_xoff      (pfc_xoff)
  );

  egr_ecc_gen u_ecc (
    .primary_clock (primary_clock),
    .rst_n         (rst_n),
    .sched         (sched_q),
    .tx_valid      (tx_valid),
    .tx_port       (tx_port),
    .tx_tc         (tx_tc),
    .tx_meta       (tx_meta),
    .tx_data       (tx_data),
    .tx_ecc        (tx_ecc)
  );

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Build the egress controller testbench with Verilator and run it
set -eo pipefail
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  --top-module egress_tb -f sources.f -o egress_sim

./obj_dir/egress_sim 2>&1 | tee sim.log

# Fail message in the log decides the result
if grep -qF "TEST FAILED" sim.log; then
  echo "Simulation reported failure"
  exit 1
fi
echo "Simulation finished without failure"

/* sim/egress_tb.sv */
//==========================================================================
// Egress port controller testbench
// Scripted and random segments, credit returns and PFC pause against a
// queue, credit and SECDED reference model, checked by assertions
//==========================================================================

`timescale 1ns/1ns

`include "egr_consts.svh"

module egress_tb;
  import egr_pkg::*;

  localparam int NPORT      = `EGR_NUM_PORTS;
  localparam int NTC        = `EGR_NUM_TC;
  localparam int DEPTH      = `EGR_FIFO_DEPTH;
  // About twice the scripted plus random run
  localparam int MAX_CYCLES = 4000;
  localparam int RAND_OPS   = 600;

  logic                   primary_clock;
  logic                   rst_n;
  logic                   in_valid;
  logic                   in_ready;
  port_idx_t              in_port;
  tc_idx_t                in_tc;
  logic [`EGR_META_W-1:0] in_meta;
  logic [`EGR_DATA_W-1:0] in_data;
  logic                   credit_valid;
  port_idx_t              credit_port;
  credit_t                credit_count;
  logic [NTC-1:0]         pfc_xoff;
  logic                   tx_valid;
  port_idx_t              tx_port;
  tc_idx_t                tx_tc;
  logic [`EGR_META_W-1:0] tx_meta;
  logic [`EGR_DATA_W-1:0] tx_data;
  logic [`EGR_ECC_W-1:0]  tx_ecc;

  //========================================================================
  // Reference model state
  //========================================================================

  // Accepted segments whose tx beat has not been seen yet
  egr_seg_t               exp_q [$];
  egr_seg_t               exp_seg;
  int                     exp_cnt;
  logic [`EGR_ECC_W-1:0]  exp_ecc;
  logic [NPORT-1:0][5:0]  ref_credit;
  // Pause mask of the previous cycle, the one a beat was sent in
  logic [NTC-1:0]         pfc_prev;
  logic                   seen_accept;
  logic                   fifo_full_ref;
  // Fast path tracking, accept then transfer
  logic                   lat1;
  logic                   lat2;
  tc_idx_t                lat1_tc;
  logic [`EGR_DATA_W-1:0] lat1_data;
  logic [`EGR_DATA_W-1:0] lat2_data;
  int                     err_value = 0;
  int                     err_other = 0;
  int                     beats = 0;
  int                     cycle_cnt = 0;
  logic                   rand_done;

  egr_top uut (.*);

  // Clock, 10 ns period
  initial begin
    primary_clock = 1'b0;
    forever #5 primary_clock = ~primary_clock;
  end

  // Extended Hamming code, data laid out by codeword position first
  function automatic logic [`EGR_ECC_W-1:0] ecc_ref(input logic [`EGR_DATA_W-1:0] d);
    logic [`EGR_DATA_W+`EGR_ECC_W-1:0] cw;
    logic [`EGR_ECC_W-1:0]             c;
    int                                j;
    cw = '0;
    c  = '0;
    j  = 0;
    for (int pos = 1; pos < `EGR_DATA_W + `EGR_ECC_W; pos++) begin
      if ($countones(pos) != 1) begin
        cw[pos] = d[j];
        j++;
      end
    end
    for (int k = 0; k < `EGR_ECC_W - 1; k++) begin
      for (int pos = 1; pos < `EGR_DATA_W + `EGR_ECC_W; pos++) begin
        if (((pos >> k) & 1) == 1) begin
          c[k] = c[k] ^ cw[pos];
        end
      end
    end
    c[`EGR_ECC_W-1] = ^{d, c[`EGR_ECC_W-2:0]};
    return c;
  endfunction

  assign exp_ecc       = ecc_ref(exp_seg.data);
  // FIFO occupancy is outstanding segments less the one just sent
  assign fifo_full_ref = (exp_cnt - int'(tx_valid)) == DEPTH;

  // Model update, sees pre-edge values like the DUT
  always @(posedge primary_clock) begin
    int       c;
    egr_seg_t s;
    if (!rst_n) begin
      exp_q.delete();
      exp_cnt     <= 0;
      exp_seg     <= '0;
      ref_credit  <= {NPORT{6'(`EGR_INIT_CREDITS)}};
      pfc_prev    <= '0;
      seen_accept <= 1'b0;
      lat1        <= 1'b0;
      lat2        <= 1'b0;
    end else begin
      if (tx_valid && exp_q.size() != 0) begin
        void'(exp_q.pop_front());
        beats++;
      end
      if (in_valid && in_ready) begin
        s = '{port: in_port, tc: in_tc, meta: in_meta, data: in_data};
        exp_q.push_back(s);
        seen_accept <= 1'b1;
      end
      // Beat consumes, return adds, saturating
      for (int p = 0; p < NPORT; p++) begin
        c = int'(ref_credit[p]);
        if (tx_valid && tx_port == port_idx_t'(p) && c > 0) begin
          c--;
        end
        if (credit_valid && credit_port == port_idx_t'(p)) begin
          c = c + int'(credit_count);
        end
        if (c > 15) begin
          c = 15;
        end
        ref_credit[p] <= 6'(c);
      end
      exp_cnt   <= exp_q.size();
      exp_seg   <= (exp_q.size() != 0) ? exp_q[0] : '0;
      pfc_prev  <= pfc_xoff;
      lat1      <= in_valid && in_ready && exp_cnt == 0 && ref_credit[in_port] != 0;
      lat1_tc   <= in_tc;
      lat1_data <= in_data;
      lat2      <= lat1 && !pfc_xoff[lat1_tc];
      lat2_data <= lat1_data;
    end
  end

  //========================================================================
  // Checks
  //========================================================================

  a_reset_idle: assert property (@(posedge primary_clock) disable iff (!rst_n)
    !seen_accept |-> (!tx_valid && in_ready))
    else begin
      $display("tx_valid or in_ready wrong before the first segment was accepted");
      err_other++;
    end

  a_beat_has_seg: assert property (@(posedge primary_clock) disable iff (!rst_n)
    tx_valid |-> exp_cnt != 0)
    else begin
      $display("tx beat seen with no accepted segment outstanding");
      err_other++;
    end

  a_tx_port: assert property (@(posedge primary_clock) disable iff (!rst_n)
    (tx_valid && exp_cnt != 0) |-> tx_port == exp_seg.port)
    else begin
      $display("[ERROR] tx_port expected %h actual %h", $sampled(exp_seg.port),
               $sampled(tx_port));
      err_value++;
    end

  a_tx_tc: assert property (@(posedge primary_clock) disable iff (!rst_n)
    (tx_valid && exp_cnt != 0) |-> tx_tc == exp_seg.tc)
    else begin
      $display("[ERROR] tx_tc expected %h actual %h", $sampled(exp_seg.tc), $sampled(tx_tc));
      err_value++;
    end

  a_tx_meta: assert property (@(posedge primary_clock) disable iff (!rst_n)
    (tx_valid && exp_cnt != 0) |-> tx_meta == exp_seg.meta)
    else begin
      $display("[ERROR] tx_meta expected %h actual %h", $sampled(exp_seg.meta),
               $sampled(tx_meta));
      err_value++;
    end

  a_tx_data: assert property (@(posedge primary_clock) disable iff (!rst_n)
    (tx_valid && exp_cnt != 0) |-> tx_data == exp_seg.data)
    else begin
      $display("[ERROR] tx_data expected %h actual %h", $sampled(exp_seg.data),
               $sampled(tx_data));
      err_value++;
    end

  a_tx_ecc: assert property (@(posedge primary_clock) disable iff (!rst_n)
    (tx_valid && exp_cnt != 0) |-> tx_ecc == exp_ecc)
    else begin
      $display("[ERROR] tx_ecc expected %h actual %h", $sampled(exp_ecc), $sampled(tx_ecc));
      err_value++;
    end

  a_credit_held: assert property (@(posedge primary_clock) disable iff (!rst_n)
    tx_valid |-> ref_credit[tx_port] != 0)
    else begin
      $display("tx beat on port %0d without any credit left", $sampled(tx_port));
      err_other++;
    end

  a_pause_held: assert property (@(posedge primary_clock) disable iff (!rst_n)
    tx_valid |-> !pfc_prev[tx_tc])
    else begin
      $display("tx beat on traffic class %0d while it was paused", $sampled(tx_tc));
      err_other++;
    end

  // Driven at edge N, accepted at N+1, on tx after N+2
  a_fast_path: assert property (@(posedge primary_clock) disable iff (!rst_n)
    lat2 |-> (tx_valid && tx_data == lat2_data))
    else begin
      $display("Segment on an open, empty path did not reach tx in time");
      err_other++;
    end

  a_in_ready: assert property (@(posedge primary_clock) disable iff (!rst_n)
    in_ready == !fifo_full_ref)
    else begin
      $display("[ERROR] in_ready expected %h actual %h", $sampled(!fifo_full_ref),
               $sampled(in_ready));
      err_value++;
    end

  //========================================================================
  // Stimulus tasks, each starts and ends just after a rising edge
  //========================================================================

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge primary_clock);
  endtask

  // Holds the segment until the FIFO takes it
  task automatic send_seg(input port_idx_t port, input tc_idx_t tc);
    in_valid <= 1'b1;
    in_port  <= port;
    in_tc    <= tc;
    in_meta  <= `EGR_META_W'($urandom);
    in_data  <= {$urandom, $urandom};
    do @(posedge primary_clock); while (!in_ready);
    in_valid <= 1'b0;
  endtask

  task automatic give_credit(input port_idx_t port, input credit_t cnt);
    credit_valid <= 1'b1;
    credit_port  <= port;
    credit_count <= cnt;
    @(posedge primary_clock);
    credit_valid <= 1'b0;
  endtask

  // Unpause and feed the oldest segment's port until all are out
  task automatic drain_all();
    pfc_xoff <= '0;
    wait_cycles(1);
    while (exp_cnt != 0) begin
      if (ref_credit[exp_seg.port] == 0) begin
        give_credit(exp_seg.port, credit_t'(2));
      end else begin
        wait_cycles(1);
      end
    end
    wait_cycles(2);
  endtask

  //========================================================================
  // Test sequence
  //========================================================================

  initial begin
    int op;
    void'($urandom(61));
    rst_n        = 1'b0;
    in_valid     = 1'b0;
    in_port      = '0;
    in_tc        = '0;
    in_meta      = '0;
    in_data      = '0;
    credit_valid = 1'b0;
    credit_port  = '0;
    credit_count = '0;
    pfc_xoff     = '0;
    rand_done    = 1'b0;
    repeat (8) @(posedge primary_clock);
    rst_n <= 1'b1;
    wait_cycles(4);

    // Lone segments on an open path, one per port
    for (int p = 0; p < NPORT; p++) begin
      send_seg(port_idx_t'(p), tc_idx_t'(0));
      wait_cycles(5);
    end

    // Port 1 runs out of credit, two segments wait for a return
    for (int i = 0; i < 4; i++) begin
      send_seg(port_idx_t'(1), tc_idx_t'(1));
    end
    wait_cycles(20);
    give_credit(port_idx_t'(1), credit_t'(3));
    drain_all();

    // Paused TC 2 at the head blocks an open segment behind it
    pfc_xoff <= NTC'(1) << 2;
    send_seg(port_idx_t'(0), tc_idx_t'(2));
    send_seg(port_idx_t'(2), tc_idx_t'(0));
    wait_cycles(15);
    drain_all();

    // Everything paused, FIFO fills and back-pressures the input
    give_credit(port_idx_t'(0), credit_t'(2));
    give_credit(port_idx_t'(2), credit_t'(2));
    give_credit(port_idx_t'(3), credit_t'(2));
    pfc_xoff <= '1;
    send_seg(port_idx_t'(0), tc_idx_t'($urandom_range(0, NTC - 1)));
    send_seg(port_idx_t'(2), tc_idx_t'($urandom_range(0, NTC - 1)));
    send_seg(port_idx_t'(3), tc_idx_t'($urandom_range(0, NTC - 1)));
    send_seg(port_idx_t'(3), tc_idx_t'($urandom_range(0, NTC - 1)));
    fork
      send_seg(port_idx_t'(0), tc_idx_t'(5));
      begin
        wait_cycles(10);
        pfc_xoff <= '0;
      end
    join
    drain_all();

    // Random traffic with returns from a separate process
    fork
      begin
        for (int i = 0; i < RAND_OPS; i++) begin
          op = $urandom_range(0, 9);
          if (op < 7) begin
            send_seg(port_idx_t'($urandom_range(0, NPORT - 1)),
                     tc_idx_t'($urandom_range(0, NTC - 1)));
          end else if (op == 7) begin
            pfc_xoff <= NTC'(1) << $urandom_range(0, NTC - 1);
            wait_cycles($urandom_range(2, 12));
            pfc_xoff <= '0;
          end else begin
            wait_cycles($urandom_range(1, 3));
          end
        end
        rand_done = 1'b1;
      end
      begin
        while (!rand_done) begin
          op = $urandom_range(0, NPORT - 1);
          // Kept well below saturation
          if (ref_credit[op] <= 8 && $urandom_range(0, 3) == 0) begin
            give_credit(port_idx_t'(op), credit_t'($urandom_range(1, 3)));
          end else begin
            wait_cycles(1);
          end
        end
      end
    join
    drain_all();
    wait_cycles(5);

    $display("Run done after %0d cycles, %0d beats, %0d value errors, %0d other errors",
             cycle_cnt, beats, err_value, err_other);
    if (err_value + err_other == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  // Run limit
  always @(posedge primary_clock) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("Run stopped at the cycle limit of %0d, the sequence did not complete",
               MAX_CYCLES);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

endmodule

/* sources.f */
+incdir+common
common/egr_pkg.sv
common/egr_seg_if.sv
hw/egr_seg_fifo.sv
hw/egr_credit_ctl.sv
hw/egr_ecc_gen.sv
hw/egr_top.sv
sim/egress_tb.sv
